// ==== Bender.yml ====
package:
  name: reg_mg

sources:
  - logic/regmg_types_pkg.sv
  - logic/regmg_map_pkg.sv
  - logic/reg_bus_if.sv
  - logic/pps_timer.sv
  - logic/reg_access.sv
  - logic/intr_ctrl.sv
  - logic/reg_mg.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_reg_mg.sv

// ==== build.f ====
+incdir+tb
logic/regmg_types_pkg.sv
logic/regmg_map_pkg.sv
logic/reg_bus_if.sv
logic/pps_timer.sv
logic/reg_access.sv
logic/intr_ctrl.sv
logic/reg_mg.sv
tb/tb_reg_mg.sv

// ==== logic/intr_ctrl.sv ====
/*
 * interrupt controller
 * captures the packet and timer events, keeps the read-to-clear time
 * status, masks the sources into the status register and drives the line
 */
`timescale 1ns/1ps

module intr_ctrl (
    input  logic                        i_rv_clk,
    input  logic                        i_rv_rst_n,
    reg_bus_if.irq                      bus,
    input  regmg_types_pkg::ram_pt_t    i_rx_wr_pt,
    input  regmg_types_pkg::ram_pt_t    i_rx_cur_pt,
    input  logic                        i_rx_ram_ful,
    input  logic                        i_pps0_pulse,
    input  logic                        i_pps1_pulse,
    input  logic                        i_wait_rvrst,
    output regmg_types_pkg::reg_data_t  o_intr_mask,
    output regmg_types_pkg::reg_data_t  o_intr_status,
    output regmg_types_pkg::reg_data_t  o_time_status,
    output logic                        o_intr_stus,
    output logic                        o_intr_start
);

    logic                       w_mask_wr;
    logic                       w_stus_wr;
    logic                       w_start_wr;
    logic                       w_time_clr;
    logic                       r_pkt_recv;
    regmg_types_pkg::reg_data_t r_src;

    assign w_mask_wr  = bus.wr && (bus.waddr == regmg_map_pkg::INTR_MASK_ADDR);
    assign w_stus_wr  = bus.wr && (bus.waddr == regmg_map_pkg::INTR_STUS_ADDR);
    assign w_start_wr = bus.wr && (bus.waddr == regmg_map_pkg::START_CFG_ADDR);
    assign w_time_clr = bus.rd && (bus.raddr == regmg_map_pkg::TIME_STUS_ADDR);

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            o_intr_start <= 1'b0;
        end else if (i_wait_rvrst) begin
            o_intr_start <= 1'b0;           // core is being reset
        end else if (w_start_wr) begin
            o_intr_start <= 1'b1;
        end
    end

    // pulses set, the registered read stage clears; a pulse wins
    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            o_time_status <= '0;
        end else begin
            if (i_pps0_pulse) begin
                o_time_status[regmg_map_pkg::TIME_PPS0_BIT] <= 1'b1;
            end else if (w_time_clr) begin
                o_time_status[regmg_map_pkg::TIME_PPS0_BIT] <= 1'b0;
            end
            if (i_pps1_pulse) begin
                o_time_status[regmg_map_pkg::TIME_PPS1_BIT] <= 1'b1;
            end else if (w_time_clr) begin
                o_time_status[regmg_map_pkg::TIME_PPS1_BIT] <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            r_pkt_recv    <= 1'b0;
            r_src         <= '0;
            o_intr_mask   <= '0;
            o_intr_status <= '0;
            o_intr_stus   <= 1'b0;
        end else begin
            r_pkt_recv <= (i_rx_wr_pt != i_rx_cur_pt) || i_rx_ram_ful;   // unread packets
            r_src      <= '0;
            r_src[regmg_map_pkg::INTR_PKT_BIT]  <= r_pkt_recv;
            r_src[regmg_map_pkg::INTR_TIME_BIT] <= |o_time_status;
            if (w_mask_wr) begin
                o_intr_mask <= regmg_types_pkg::byte_merge(o_intr_mask, bus.wdata, bus.bmask);
            end
            if (w_stus_wr) begin
                // software override, lasts until the next masked update
                o_intr_status <= regmg_types_pkg::byte_merge(o_intr_status, bus.wdata,
                                                             bus.bmask);
            end else begin
                o_intr_status <= r_src & o_intr_mask;
            end
            o_intr_stus <= |o_intr_status;
        end
    end

    a_status_masked: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        !$past(w_stus_wr) |-> ((o_intr_status & ~$past(o_intr_mask)) == '0));

endmodule

// ==== logic/pps_timer.sv ====
/*
 * periodic pulse timer
 * 48-bit counter that pulses for one cycle and wraps every period+1 cycles
 */
`timescale 1ns/1ps

module pps_timer (
    input  logic                          i_rv_clk,
    input  logic                          i_rv_rst_n,
    input  logic                          i_enable,
    input  regmg_types_pkg::pps_period_t  i_period,
    output logic                          o_pulse
);

    regmg_types_pkg::pps_period_t r_cnt;

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            r_cnt   <= '0;
            o_pulse <= 1'b0;
        end else if (!i_enable) begin
            r_cnt   <= '0;                  // restart from zero on next enable
            o_pulse <= 1'b0;
        end else if (r_cnt == i_period) begin
            r_cnt   <= '0;
            o_pulse <= 1'b1;
        end else begin
            r_cnt   <= r_cnt + 48'd1;
            o_pulse <= 1'b0;
        end
    end

    a_pulse_needs_en: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        o_pulse |-> $past(i_enable));

endmodule

// ==== logic/reg_access.sv ====
/*
 * register access block
 * decodes byte-masked writes into the config, pointer and timer registers,
 * handles the self-clearing soft reset and drives the registered read path
 */
`timescale 1ns/1ps

module reg_access (
    input  logic                          i_rv_clk,
    input  logic                          i_rv_rst_n,
    input  regmg_types_pkg::reg_addr_t    i_reg_addr,
    input  regmg_types_pkg::reg_data_t    i_reg_din,
    input  logic                          i_reg_en,
    input  regmg_types_pkg::byte_en_t     i_reg_we,
    output regmg_types_pkg::reg_data_t    o_reg_dout,
    reg_bus_if.acc                        bus,
    input  logic                          i_wait_rvrst,
    output logic                          o_soft_rst_en,
    output regmg_types_pkg::ram_pt_t      o_start_cfg,
    output regmg_types_pkg::ram_pt_t      o_rx_cur_pt,
    output regmg_types_pkg::ram_pt_t      o_tx_wr_pt,
    input  regmg_types_pkg::ram_pt_t      i_rx_wr_pt,
    input  regmg_types_pkg::ram_pt_t      i_rx_rd_pt,
    input  regmg_types_pkg::ram_pt_t      i_tx_rd_pt,
    input  logic                          i_rx_ram_ful,
    input  logic                          i_tx_ram_ful,
    output logic                          o_pps0_en,
    output logic                          o_pps1_en,
    output regmg_types_pkg::pps_period_t  o_pps0_period,
    output regmg_types_pkg::pps_period_t  o_pps1_period,
    input  regmg_types_pkg::reg_data_t    i_intr_mask,
    input  regmg_types_pkg::reg_data_t    i_intr_status,
    input  regmg_types_pkg::reg_data_t    i_time_status
);

    regmg_types_pkg::reg_data_t w_bmask;
    logic                       w_wr;
    logic                       r_rd;
    regmg_types_pkg::reg_addr_t r_raddr;
    logic                       r_wait_rvrst;
    regmg_types_pkg::reg_data_t r_sw_ver;
    regmg_types_pkg::reg_data_t r_pps0_inv_l;
    regmg_types_pkg::reg_data_t r_pps0_inv_h;
    regmg_types_pkg::reg_data_t r_pps1_inv_l;
    regmg_types_pkg::reg_data_t r_pps1_inv_h;

    assign w_bmask = {{8{i_reg_we[3]}}, {8{i_reg_we[2]}}, {8{i_reg_we[1]}}, {8{i_reg_we[0]}}};
    assign w_wr    = i_reg_en && (|i_reg_we);

    assign bus.wr    = w_wr;
    assign bus.waddr = i_reg_addr;
    assign bus.wdata = i_reg_din;
    assign bus.bmask = w_bmask;
    assign bus.rd    = r_rd;
    assign bus.raddr = r_raddr;

    // high word holds the enable in bit 31 and period bits 47:32 below it
    assign o_pps0_en     = r_pps0_inv_h[regmg_map_pkg::PPS_EN_BIT];
    assign o_pps1_en     = r_pps1_inv_h[regmg_map_pkg::PPS_EN_BIT];
    assign o_pps0_period = {r_pps0_inv_h[15:0], r_pps0_inv_l};
    assign o_pps1_period = {r_pps1_inv_h[15:0], r_pps1_inv_l};

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            o_start_cfg  <= '0;
            o_rx_cur_pt  <= '0;
            o_tx_wr_pt   <= '0;
            r_sw_ver     <= '0;
            r_pps0_inv_l <= '0;
            r_pps0_inv_h <= '0;
            r_pps1_inv_l <= '0;
            r_pps1_inv_h <= '0;
        end else if (w_wr) begin
            case (i_reg_addr)
                regmg_map_pkg::START_CFG_ADDR: begin
                    o_start_cfg <= regmg_types_pkg::ram_pt_t'(regmg_types_pkg::byte_merge(
                        {28'b0, o_start_cfg}, i_reg_din, w_bmask));
                end
                regmg_map_pkg::RX_CUR_PT_ADDR: begin
                    o_rx_cur_pt <= regmg_types_pkg::ram_pt_t'(regmg_types_pkg::byte_merge(
                        {28'b0, o_rx_cur_pt}, i_reg_din, w_bmask));
                end
                regmg_map_pkg::TX_WR_PT_ADDR: begin
                    o_tx_wr_pt <= regmg_types_pkg::ram_pt_t'(regmg_types_pkg::byte_merge(
                        {28'b0, o_tx_wr_pt}, i_reg_din, w_bmask));
                end
                regmg_map_pkg::SW_VER_ADDR: begin
                    r_sw_ver <= regmg_types_pkg::byte_merge(r_sw_ver, i_reg_din, w_bmask);
                end
                regmg_map_pkg::PPS0_INV_L_ADDR: begin
                    r_pps0_inv_l <= regmg_types_pkg::byte_merge(r_pps0_inv_l, i_reg_din, w_bmask);
                end
                regmg_map_pkg::PPS0_INV_H_ADDR: begin
                    r_pps0_inv_h <= regmg_types_pkg::byte_merge(r_pps0_inv_h, i_reg_din, w_bmask);
                end
                regmg_map_pkg::PPS1_INV_L_ADDR: begin
                    r_pps1_inv_l <= regmg_types_pkg::byte_merge(r_pps1_inv_l, i_reg_din, w_bmask);
                end
                regmg_map_pkg::PPS1_INV_H_ADDR: begin
                    r_pps1_inv_h <= regmg_types_pkg::byte_merge(r_pps1_inv_h, i_reg_din, w_bmask);
                end
                default: ;                              // mask/status live in intr_ctrl
            endcase
        end
    end

    // soft reset stays up until the reset controller drops its wait flag
    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            o_soft_rst_en <= 1'b0;
            r_wait_rvrst  <= 1'b0;
        end else begin
            r_wait_rvrst <= i_wait_rvrst;
            if (w_wr && (i_reg_addr == regmg_map_pkg::SOFT_RST_EN_ADDR)) begin
                o_soft_rst_en <= (i_reg_din[0] & w_bmask[0]) | (o_soft_rst_en & ~w_bmask[0]);
            end else if (r_wait_rvrst && !i_wait_rvrst) begin
                o_soft_rst_en <= 1'b0;                  // reset sequence finished
            end
        end
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            r_rd    <= 1'b0;
            r_raddr <= '0;
        end else begin
            r_rd    <= i_reg_en && !(|i_reg_we);
            r_raddr <= i_reg_addr;
        end
    end

    always_ff @(posedge i_rv_clk) begin
        if (!i_rv_rst_n) begin
            o_reg_dout <= '0;
        end else if (r_rd) begin
            case (r_raddr)
                regmg_map_pkg::START_CFG_ADDR:   o_reg_dout <= {28'b0, o_start_cfg};
                regmg_map_pkg::SW_VER_ADDR:      o_reg_dout <= r_sw_ver;
                regmg_map_pkg::HW_VER_ADDR:      o_reg_dout <= regmg_map_pkg::HW_VER_DATE;
                regmg_map_pkg::INTR_MASK_ADDR:   o_reg_dout <= i_intr_mask;
                regmg_map_pkg::INTR_STUS_ADDR:   o_reg_dout <= i_intr_status;
                regmg_map_pkg::TIME_STUS_ADDR:   o_reg_dout <= i_time_status;
                regmg_map_pkg::RX_WR_PT_ADDR:    o_reg_dout <= {28'b0, i_rx_wr_pt};
                regmg_map_pkg::RX_CUR_PT_ADDR:   o_reg_dout <= {28'b0, o_rx_cur_pt};
                regmg_map_pkg::RX_RD_PT_ADDR:    o_reg_dout <= {28'b0, i_rx_rd_pt};
                regmg_map_pkg::TX_WR_PT_ADDR:    o_reg_dout <= {28'b0, o_tx_wr_pt};
                regmg_map_pkg::TX_RD_PT_ADDR:    o_reg_dout <= {28'b0, i_tx_rd_pt};
                regmg_map_pkg::RX_RAM_FULL_ADDR: o_reg_dout <= {31'b0, i_rx_ram_ful};
                regmg_map_pkg::TX_RAM_FULL_ADDR: o_reg_dout <= {31'b0, i_tx_ram_ful};
                regmg_map_pkg::PPS0_INV_L_ADDR:  o_reg_dout <= r_pps0_inv_l;
                regmg_map_pkg::PPS0_INV_H_ADDR:  o_reg_dout <= r_pps0_inv_h;
                regmg_map_pkg::PPS1_INV_L_ADDR:  o_reg_dout <= r_pps1_inv_l;
                regmg_map_pkg::PPS1_INV_H_ADDR:  o_reg_dout <= r_pps1_inv_h;
                default:                         o_reg_dout <= o_reg_dout;   // unmapped, hold
            endcase
        end
    end

    // the wait phase alone never requests a new soft reset
    a_soft_rst_quiet: assert property (@(posedge i_rv_clk) disable iff (!i_rv_rst_n)
        (i_wait_rvrst && !o_soft_rst_en && !w_wr) |=> !o_soft_rst_en);

endmodule

// ==== logic/reg_bus_if.sv ====
/*
 * decoded register bus
 * write and registered read strobes from the access block to the
 * interrupt block, so both decode the same request
 */
`timescale 1ns/1ps

interface reg_bus_if;

    logic                       wr;     // enable with at least one byte lane
    regmg_types_pkg::reg_addr_t waddr;
    regmg_types_pkg::reg_data_t wdata;
    regmg_types_pkg::reg_data_t bmask;  // byte enables widened to 8 bits each
    logic                       rd;     // read enable, one cycle late
    regmg_types_pkg::reg_addr_t raddr;  // read address, one cycle late

    modport acc (
        output wr, waddr, wdata, bmask,
        output rd, raddr
    );

    modport irq (
        input wr, waddr, wdata, bmask,
        input rd, raddr
    );

endinterface

// ==== logic/reg_mg.sv ====
/*
 * register manager top
 * register access, two pulse timers and the interrupt controller
 */
`timescale 1ns/1ps

module reg_mg (
    input  logic                        i_rv_clk,
    input  logic                        i_rv_rst_n,
    input  regmg_types_pkg::reg_addr_t  i_reg_addr,
    input  regmg_types_pkg::reg_data_t  i_reg_din,
    output regmg_types_pkg::reg_data_t  o_reg_dout,
    input  logic                        i_reg_en,
    input  regmg_types_pkg::byte_en_t   i_reg_we,
    output logic                        o_intr_stus,
    output logic                        o_intr_start,
    output logic                        o_soft_rst_en,
    input  logic                        i_wait_rvrst,
    output regmg_types_pkg::ram_pt_t    o_start_cfg,
    input  regmg_types_pkg::ram_pt_t    i_rx_wr_pt,
    output regmg_types_pkg::ram_pt_t    o_rx_cur_pt,
    input  regmg_types_pkg::ram_pt_t    i_rx_rd_pt,
    output regmg_types_pkg::ram_pt_t    o_tx_wr_pt,
    input  regmg_types_pkg::ram_pt_t    i_tx_rd_pt,
    input  logic                        i_rx_ram_ful,
    input  logic                        i_tx_ram_ful
);

    logic                         pps0_en;
    logic                         pps1_en;
    regmg_types_pkg::pps_period_t pps0_period;
    regmg_types_pkg::pps_period_t pps1_period;
    logic                         pps0_pulse;
    logic                         pps1_pulse;
    regmg_types_pkg::reg_data_t   intr_mask;
    regmg_types_pkg::reg_data_t   intr_status;
    regmg_types_pkg::reg_data_t   time_status;

    reg_bus_if u_reg_bus ();

    reg_access u_reg_access (
        .i_rv_clk      (i_rv_clk),
        .i_rv_rst_n    (i_rv_rst_n),
        .i_reg_addr    (i_reg_addr),
        .i_reg_din     (i_reg_din),
        .i_reg_en      (i_reg_en),
        .i_reg_we      (i_reg_we),
        .o_reg_dout    (o_reg_dout),
        .bus           (u_reg_bus.acc),
        .i_wait_rvrst  (i_wait_rvrst),
        .o_soft_rst_en (o_soft_rst_en),
        .o_start_cfg   (o_start_cfg),
        .o_rx_cur_pt   (o_rx_cur_pt),
        .o_tx_wr_pt    (o_tx_wr_pt),
        .i_rx_wr_pt    (i_rx_wr_pt),
        .i_rx_rd_pt    (i_rx_rd_pt),
        .i_tx_rd_pt    (i_tx_rd_pt),
        .i_rx_ram_ful  (i_rx_ram_ful),
        .i_tx_ram_ful  (i_tx_ram_ful),
        .o_pps0_en     (pps0_en),
        .o_pps1_en     (pps1_en),
        .o_pps0_period (pps0_period),
        .o_pps1_period (pps1_period),
        .i_intr_mask   (intr_mask),
        .i_intr_status (intr_status),
        .i_time_status (time_status)
    );

    pps_timer u_pps0 (
        .i_rv_clk   (i_rv_clk),
        .i_rv_rst_n (i_rv_rst_n),
        .i_enable   (pps0_en),
        .i_period   (pps0_period),
        .o_pulse    (pps0_pulse)
    );

    pps_timer u_pps1 (
        .i_rv_clk   (i_rv_clk),
        .i_rv_rst_n (i_rv_rst_n),
        .i_enable   (pps1_en),
        .i_period   (pps1_period),
        .o_pulse    (pps1_pulse)
    );

    intr_ctrl u_intr_ctrl (
        .i_rv_clk      (i_rv_clk),
        .i_rv_rst_n    (i_rv_rst_n),
        .bus           (u_reg_bus.irq),
        .i_rx_wr_pt    (i_rx_wr_pt),
        .i_rx_cur_pt   (o_rx_cur_pt),
        .i_rx_ram_ful  (i_rx_ram_ful),
        .i_pps0_pulse  (pps0_pulse),
        .i_pps1_pulse  (pps1_pulse),
        .i_wait_rvrst  (i_wait_rvrst),
        .o_intr_mask   (intr_mask),
        .o_intr_status (intr_status),
        .o_time_status (time_status),
        .o_intr_stus   (o_intr_stus),
        .o_intr_start  (o_intr_start)
    );

endmodule

// ==== logic/regmg_map_pkg.sv ====
/*
 * register manager address map
 * word addresses, the fixed hardware version and the bit positions
 * used in the timer, interrupt and time status registers
 */
package regmg_map_pkg;

    localparam regmg_types_pkg::reg_addr_t START_CFG_ADDR   = 12'h000;
    localparam regmg_types_pkg::reg_addr_t SOFT_RST_EN_ADDR = 12'h001;
    localparam regmg_types_pkg::reg_addr_t SW_VER_ADDR      = 12'h002;
    localparam regmg_types_pkg::reg_addr_t HW_VER_ADDR      = 12'h003;
    localparam regmg_types_pkg::reg_addr_t INTR_MASK_ADDR   = 12'h010;
    localparam regmg_types_pkg::reg_addr_t INTR_STUS_ADDR   = 12'h011;
    localparam regmg_types_pkg::reg_addr_t TIME_STUS_ADDR   = 12'h012;   // read to clear
    localparam regmg_types_pkg::reg_addr_t RX_WR_PT_ADDR    = 12'h020;
    localparam regmg_types_pkg::reg_addr_t RX_CUR_PT_ADDR   = 12'h021;
    localparam regmg_types_pkg::reg_addr_t RX_RD_PT_ADDR    = 12'h022;
    localparam regmg_types_pkg::reg_addr_t TX_WR_PT_ADDR    = 12'h023;
    localparam regmg_types_pkg::reg_addr_t TX_RD_PT_ADDR    = 12'h024;
    localparam regmg_types_pkg::reg_addr_t RX_RAM_FULL_ADDR = 12'h025;
    localparam regmg_types_pkg::reg_addr_t TX_RAM_FULL_ADDR = 12'h026;
    localparam regmg_types_pkg::reg_addr_t PPS0_INV_L_ADDR  = 12'h032;
    localparam regmg_types_pkg::reg_addr_t PPS0_INV_H_ADDR  = 12'h033;
    localparam regmg_types_pkg::reg_addr_t PPS1_INV_L_ADDR  = 12'h034;
    localparam regmg_types_pkg::reg_addr_t PPS1_INV_H_ADDR  = 12'h035;

    localparam regmg_types_pkg::reg_data_t HW_VER_DATE = 32'h2022_0108;

    localparam int PPS_EN_BIT    = 31;  // in the high period word
    localparam int TIME_PPS0_BIT = 0;
    localparam int TIME_PPS1_BIT = 1;
    localparam int INTR_PKT_BIT  = 0;
    localparam int INTR_TIME_BIT = 1;

endpackage

// ==== logic/regmg_types_pkg.sv ====
/*
 * register manager types
 * widths of the register bus, the buffer pointers and the pulse timers,
 * plus the byte-merge rule shared by every writable register
 */
package regmg_types_pkg;

    typedef logic [11:0] reg_addr_t;    // register word address
    typedef logic [31:0] reg_data_t;    // register bus word
    typedef logic [3:0]  byte_en_t;     // one enable per byte lane
    typedef logic [3:0]  ram_pt_t;      // rx/tx buffer slot pointer
    typedef logic [47:0] pps_period_t;  // timer period and count

    // enabled bytes come from the bus, the rest keep their old value
    function automatic reg_data_t byte_merge(input reg_data_t old_val,
                                             input reg_data_t new_val,
                                             input reg_data_t mask);
        return (new_val & mask) | (old_val & ~mask);
    endfunction

endpackage

// ==== tb/tb_reg_mg_checks.svh ====
/*
 * testbench checks
 * compare tasks per result type, error counters and a galois lfsr
 */

int          error_count = 0;
int          check_count = 0;
logic [15:0] lfsr_state  = 16'd10803;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);    // taps 16 14 13 11
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output regmg_types_pkg::reg_data_t v);
    v = '0;
    repeat (n) begin
        v          = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

task automatic check_data(input string name, input regmg_types_pkg::reg_data_t got,
                          input regmg_types_pkg::reg_data_t exp);
    check_count++;
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_pt(input string name, input regmg_types_pkg::ram_pt_t got,
                        input regmg_types_pkg::ram_pt_t exp);
    check_count++;
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        error_count++;
    end
endtask

// ==== tb/tb_reg_mg.sv ====
/*
 * register manager testbench
 * table of register accesses, then soft reset, packet interrupt and timer runs
 */
`timescale 1ns/1ps

module tb_reg_mg;

    localparam int RESET_CYCLES = 16;
    localparam int SCEN_CYCLES  = 160;     // soft reset, interrupt and timer runs
    localparam int PPS_PERIOD   = 20;
    localparam regmg_types_pkg::ram_pt_t RX_WR_VAL = 4'h5;
    localparam regmg_types_pkg::ram_pt_t RX_RD_VAL = 4'h9;
    localparam regmg_types_pkg::ram_pt_t TX_RD_VAL = 4'hc;

    typedef struct packed {
        logic                       is_wr;
        regmg_types_pkg::reg_addr_t addr;
        regmg_types_pkg::reg_data_t data;
        regmg_types_pkg::byte_en_t  be;
        regmg_types_pkg::reg_data_t exp;    // read value or register value after a write
    } access_t;

    logic                       i_rv_clk;
    logic                       i_rv_rst_n;
    regmg_types_pkg::reg_addr_t i_reg_addr;
    regmg_types_pkg::reg_data_t i_reg_din;
    regmg_types_pkg::reg_data_t o_reg_dout;
    logic                       i_reg_en;
    regmg_types_pkg::byte_en_t  i_reg_we;
    logic                       o_intr_stus;
    logic                       o_intr_start;
    logic                       o_soft_rst_en;
    logic                       i_wait_rvrst;
    regmg_types_pkg::ram_pt_t   o_start_cfg;
    regmg_types_pkg::ram_pt_t   i_rx_wr_pt;
    regmg_types_pkg::ram_pt_t   o_rx_cur_pt;
    regmg_types_pkg::ram_pt_t   i_rx_rd_pt;
    regmg_types_pkg::ram_pt_t   o_tx_wr_pt;
    regmg_types_pkg::ram_pt_t   i_tx_rd_pt;
    logic                       i_rx_ram_ful;
    logic                       i_tx_ram_ful;

    access_t                    table_q[$];
    regmg_types_pkg::reg_data_t model_sw   = '0;
    regmg_types_pkg::reg_data_t model_cur  = '0;
    regmg_types_pkg::reg_data_t model_txwr = '0;
    int                         cycles      = 0;
    int                         cycle_limit = 1000;

    `include "tb_reg_mg_checks.svh"

    reg_mg i_reg_mg (.*);

    initial begin
        i_rv_clk = 1'b0;
        forever #2 i_rv_clk = ~i_rv_clk;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge i_rv_clk);
            cycles++;
        end
        $display("timeout, the run went past %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    function automatic regmg_types_pkg::reg_data_t merge_bytes(
        input regmg_types_pkg::reg_data_t old_val,
        input regmg_types_pkg::reg_data_t new_val,
        input regmg_types_pkg::byte_en_t  be);
        regmg_types_pkg::reg_data_t r;
        int                         b;
        r = old_val;
        for (b = 0; b < 4; b++) begin
            if (be[b]) r[8*b +: 8] = new_val[8*b +: 8];
        end
        return r;
    endfunction

    task automatic wait_cycle();
        @(posedge i_rv_clk);
        #1;                                 // drive and sample away from the edge
    endtask

    task automatic bus_write(input regmg_types_pkg::reg_addr_t addr,
                             input regmg_types_pkg::reg_data_t data,
                             input regmg_types_pkg::byte_en_t  be);
        i_reg_addr = addr;
        i_reg_din  = data;
        i_reg_we   = be;
        i_reg_en   = 1'b1;
        wait_cycle();
        i_reg_en   = 1'b0;
        i_reg_we   = '0;
    endtask

    // o_reg_dout holds the result two edges after the request
    task automatic bus_read(input regmg_types_pkg::reg_addr_t addr);
        i_reg_addr = addr;
        i_reg_we   = '0;
        i_reg_en   = 1'b1;
        wait_cycle();
        i_reg_en   = 1'b0;
        wait_cycle();
    endtask

    task automatic add_write(input regmg_types_pkg::reg_addr_t addr,
                             input regmg_types_pkg::byte_en_t  be);
        access_t ent;
        draw_bits(32, ent.data);
        ent.is_wr = 1'b1;
        ent.addr  = addr;
        ent.be    = be;
        case (addr)
            regmg_map_pkg::SW_VER_ADDR: begin
                model_sw = merge_bytes(model_sw, ent.data, be);
                ent.exp  = model_sw;
            end
            regmg_map_pkg::RX_CUR_PT_ADDR: begin
                model_cur = merge_bytes(model_cur, ent.data, be) & 32'h0000_000f;
                ent.exp   = model_cur;
            end
            default: begin
                model_txwr = merge_bytes(model_txwr, ent.data, be) & 32'h0000_000f;
                ent.exp    = model_txwr;
            end
        endcase
        table_q.push_back(ent);
    endtask

    task automatic add_read(input regmg_types_pkg::reg_addr_t addr,
                            input regmg_types_pkg::reg_data_t exp);
        table_q.push_back({1'b0, addr, 32'h0, 4'h0, exp});
    endtask

    task automatic wait_intr_line(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (o_intr_stus !== level && n < max_cycles) begin
            wait_cycle();
            n++;
        end
        check_count++;
        if (o_intr_stus !== level) begin
            $display("o_intr_stus did not go to %0b within %0d cycles", level, max_cycles);
            error_count++;
        end
    endtask

    initial begin
        access_t ent;
        int      idx;
        i_rv_rst_n   = 1'b0;
        i_reg_addr   = '0;
        i_reg_din    = '0;
        i_reg_en     = 1'b0;
        i_reg_we     = '0;
        i_wait_rvrst = 1'b0;
        i_rx_wr_pt   = '0;
        i_rx_rd_pt   = '0;
        i_tx_rd_pt   = '0;
        i_rx_ram_ful = 1'b0;
        i_tx_ram_ful = 1'b0;

        add_read(regmg_map_pkg::HW_VER_ADDR, regmg_map_pkg::HW_VER_DATE);
        add_read(12'h0ff, regmg_map_pkg::HW_VER_DATE);          // unmapped address keeps dout
        add_read(regmg_map_pkg::SW_VER_ADDR, 32'h0);
        add_write(regmg_map_pkg::SW_VER_ADDR, 4'hf);
        add_read(regmg_map_pkg::SW_VER_ADDR, model_sw);
        add_write(regmg_map_pkg::SW_VER_ADDR, 4'h5);
        add_read(regmg_map_pkg::SW_VER_ADDR, model_sw);
        add_write(regmg_map_pkg::SW_VER_ADDR, 4'ha);
        add_read(regmg_map_pkg::SW_VER_ADDR, model_sw);
        add_write(regmg_map_pkg::RX_CUR_PT_ADDR, 4'hf);
        add_read(regmg_map_pkg::RX_CUR_PT_ADDR, model_cur);
        add_write(regmg_map_pkg::RX_CUR_PT_ADDR, 4'he);         // low byte kept
        add_read(regmg_map_pkg::RX_CUR_PT_ADDR, model_cur);
        add_write(regmg_map_pkg::TX_WR_PT_ADDR, 4'h1);
        add_read(regmg_map_pkg::TX_WR_PT_ADDR, model_txwr);
        add_write(regmg_map_pkg::TX_WR_PT_ADDR, 4'h2);
        add_read(regmg_map_pkg::TX_WR_PT_ADDR, model_txwr);
        add_read(regmg_map_pkg::RX_WR_PT_ADDR, {28'h0, RX_WR_VAL});
        add_read(regmg_map_pkg::RX_RD_PT_ADDR, {28'h0, RX_RD_VAL});
        add_read(regmg_map_pkg::TX_RD_PT_ADDR, {28'h0, TX_RD_VAL});
        add_read(regmg_map_pkg::RX_RAM_FULL_ADDR, 32'h1);
        add_read(regmg_map_pkg::TX_RAM_FULL_ADDR, 32'h1);
        cycle_limit = 2 * (RESET_CYCLES + 2 * table_q.size() + SCEN_CYCLES);

        repeat (RESET_CYCLES) wait_cycle();
        i_rv_rst_n = 1'b1;
        check_data("o_reg_dout", o_reg_dout, 32'h0);
        check_bit("o_soft_rst_en", o_soft_rst_en, 1'b0);
        check_bit("o_intr_start", o_intr_start, 1'b0);
        check_bit("o_intr_stus", o_intr_stus, 1'b0);
        check_pt("o_start_cfg", o_start_cfg, 4'h0);
        check_pt("o_rx_cur_pt", o_rx_cur_pt, 4'h0);
        check_pt("o_tx_wr_pt", o_tx_wr_pt, 4'h0);

        i_rx_wr_pt   = RX_WR_VAL;
        i_rx_rd_pt   = RX_RD_VAL;
        i_tx_rd_pt   = TX_RD_VAL;
        i_rx_ram_ful = 1'b1;
        i_tx_ram_ful = 1'b1;
        for (idx = 0; idx < table_q.size(); idx++) begin
            ent = table_q[idx];
            if (ent.is_wr) begin
                bus_write(ent.addr, ent.data, ent.be);
                if (ent.addr == regmg_map_pkg::RX_CUR_PT_ADDR) begin
                    check_pt("o_rx_cur_pt", o_rx_cur_pt, ent.exp[3:0]);
                end else if (ent.addr == regmg_map_pkg::TX_WR_PT_ADDR) begin
                    check_pt("o_tx_wr_pt", o_tx_wr_pt, ent.exp[3:0]);
                end
            end else begin
                bus_read(ent.addr);
                check_data("o_reg_dout", o_reg_dout, ent.exp);
            end
        end

        // soft reset and interrupt start against the reset controller wait
        bus_write(regmg_map_pkg::START_CFG_ADDR, 32'h3, 4'hf);
        check_pt("o_start_cfg", o_start_cfg, 4'h3);
        check_bit("o_intr_start", o_intr_start, 1'b1);
        bus_write(regmg_map_pkg::SOFT_RST_EN_ADDR, 32'h1, 4'h1);
        check_bit("o_soft_rst_en", o_soft_rst_en, 1'b1);
        i_wait_rvrst = 1'b1;
        wait_cycle();
        check_bit("o_intr_start", o_intr_start, 1'b0);
        repeat (3) wait_cycle();
        i_wait_rvrst = 1'b0;
        check_bit("o_soft_rst_en", o_soft_rst_en, 1'b1);
        wait_cycle();
        check_bit("o_soft_rst_en", o_soft_rst_en, 1'b0);

        // packet interrupt from a pointer difference and then from full
        i_rx_ram_ful = 1'b0;
        i_tx_ram_ful = 1'b0;
        i_rx_wr_pt   = model_cur[3:0];
        repeat (4) wait_cycle();
        bus_write(regmg_map_pkg::INTR_MASK_ADDR, 32'h1, 4'hf);
        repeat (4) wait_cycle();
        check_bit("o_intr_stus", o_intr_stus, 1'b0);
        i_rx_wr_pt = model_cur[3:0] + 4'h1;
        wait_intr_line(1'b1, 4);
        bus_write(regmg_map_pkg::INTR_MASK_ADDR, 32'h0, 4'hf);
        wait_intr_line(1'b0, 4);
        i_rx_wr_pt = model_cur[3:0];
        repeat (4) wait_cycle();
        bus_write(regmg_map_pkg::INTR_MASK_ADDR, 32'h1, 4'hf);
        repeat (4) wait_cycle();
        check_bit("o_intr_stus", o_intr_stus, 1'b0);
        i_rx_ram_ful = 1'b1;
        wait_intr_line(1'b1, 4);
        i_rx_ram_ful = 1'b0;
        bus_write(regmg_map_pkg::INTR_MASK_ADDR, 32'h0, 4'hf);

        // pps0 pulses every period+1 cycles so each read sees one pulse
        bus_write(regmg_map_pkg::PPS0_INV_L_ADDR, PPS_PERIOD, 4'hf);
        bus_write(regmg_map_pkg::PPS0_INV_H_ADDR, 32'h8000_0000, 4'hf);
        repeat (PPS_PERIOD + 1) wait_cycle();
        repeat (3) begin
            bus_read(regmg_map_pkg::TIME_STUS_ADDR);
            check_data("o_reg_dout", o_reg_dout, 32'h0000_0001);     // pps0 bit
            repeat (PPS_PERIOD - 1) wait_cycle();
        end
        bus_write(regmg_map_pkg::PPS0_INV_H_ADDR, 32'h0, 4'hf);
        bus_read(regmg_map_pkg::TIME_STUS_ADDR);                    // drains a last pulse
        repeat (PPS_PERIOD + 1) wait_cycle();                       // a full period with no pulse
        bus_read(regmg_map_pkg::TIME_STUS_ADDR);
        check_data("o_reg_dout", o_reg_dout, 32'h0);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
